/* icache_top.f */
logic/cache_geom_pkg.sv
logic/fetch_types_pkg.sv
logic/l1_icache_array.sv
logic/victim_icache.sv
logic/icache_miss_ctrl.sv
logic/icache_top.sv
tests/tb_clock_gen.sv
tests/icache_tb.sv

/* logic/cache_geom_pkg.sv */
// address and line geometry shared by the instruction cache RTL; import where widths are needed
package cache_geom_pkg;

    localparam int WORD_BITS       = 32;
    localparam int LINE_BITS       = 512;
    localparam int TAG_BITS        = 20;
    localparam int INDEX_BITS      = 6;
    localparam int OFFSET_BITS     = 4;
    localparam int L1_SETS         = 64;
    localparam int VICTIM_ENTRIES  = 4;
    localparam int VICTIM_PTR_BITS = 2;

    typedef logic [LINE_BITS-1:0]             line_t;
    typedef logic [TAG_BITS-1:0]              tag_t;
    typedef logic [INDEX_BITS-1:0]            index_t;
    typedef logic [TAG_BITS+INDEX_BITS-1:0]   line_addr_t;
    typedef logic [OFFSET_BITS-1:0]           word_off_t;
    typedef logic [31:0]                      fetch_addr_t;
    typedef logic [WORD_BITS-1:0]             word_t;

    // byte address is tag | index | word offset | 2 byte bits
    function automatic tag_t addr_tag(input fetch_addr_t a);
        return a[31 -: TAG_BITS];
    endfunction

    function automatic index_t addr_index(input fetch_addr_t a);
        return a[2+OFFSET_BITS +: INDEX_BITS];
    endfunction

    function automatic word_off_t addr_word(input fetch_addr_t a);
        return a[2 +: OFFSET_BITS];
    endfunction

endpackage

/* logic/fetch_types_pkg.sv */
// transaction structs and the miss FSM states passed between fetch, memory and cache blocks
package fetch_types_pkg;

    // where a returned word came from
    typedef enum logic [1:0] {
        src_l1,
        src_victim,
        src_mem
    } src_t;

    typedef struct packed {
        cache_geom_pkg::fetch_addr_t addr;
    } fetch_req_t;

    typedef struct packed {
        cache_geom_pkg::word_t word;
        src_t                  src;
    } fetch_rsp_t;

    typedef struct packed {
        cache_geom_pkg::line_addr_t line_addr;
    } mem_req_t;

    typedef struct packed {
        cache_geom_pkg::line_t line;
    } mem_rsp_t;

    // line displaced from the L1
    typedef struct packed {
        cache_geom_pkg::line_addr_t line_addr;
        cache_geom_pkg::line_t      line;
    } victim_wr_t;

    typedef struct packed {
        cache_geom_pkg::index_t index;
        cache_geom_pkg::tag_t   tag;
        cache_geom_pkg::line_t  line;
    } l1_fill_t;

    typedef enum logic [2:0] {
        st_idle,
        st_lookup,
        st_mem_wait,
        st_fill,
        st_respond
    } miss_state_t;

endpackage

/* logic/icache_miss_ctrl.sv */
// miss FSM for the instruction cache; picks L1, victim or memory line, refills and evicts
`timescale 1ns/100ps

module icache_miss_ctrl (
    input  logic                          clk,
    input  logic                          rstn,
    input  logic                          req_valid,
    input  fetch_types_pkg::fetch_req_t   req,
    output logic                          req_ready,
    output logic                          rsp_valid,
    output fetch_types_pkg::fetch_rsp_t   rsp,
    output logic                          mem_req_valid,
    output fetch_types_pkg::mem_req_t     mem_req,
    input  logic                          mem_rsp_valid,
    input  fetch_types_pkg::mem_rsp_t     mem_rsp,
    output cache_geom_pkg::index_t        lookup_index,
    input  logic                          l1_valid,
    input  cache_geom_pkg::tag_t          l1_tag,
    input  cache_geom_pkg::line_t         l1_line,
    output logic                          l1_fill_en,
    output fetch_types_pkg::l1_fill_t     l1_fill,
    output cache_geom_pkg::line_addr_t    lookup_line_addr,
    input  logic                          victim_hit,
    input  cache_geom_pkg::line_t         victim_line,
    output logic                          victim_we,
    output fetch_types_pkg::victim_wr_t   victim_wr
);
    import cache_geom_pkg::*;
    import fetch_types_pkg::*;

    miss_state_t  state;
    fetch_addr_t  addr_q;
    line_t        line_q;
    src_t         src_q;
    victim_wr_t   victim_wr_q;
    logic         mem_req_q;
    tag_t         req_tag;
    index_t       req_index;
    word_off_t    req_word;
    logic         l1_hit;

    assign req_tag   = addr_tag(addr_q);
    assign req_index = addr_index(addr_q);
    assign req_word  = addr_word(addr_q);

    // both arrays are always looked up with the held address
    assign lookup_index     = req_index;
    assign lookup_line_addr = {req_tag, req_index};

    assign l1_hit = l1_valid && (l1_tag == req_tag);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state     <= st_idle;
            mem_req_q <= 1'b0;
        end else begin
            mem_req_q <= 1'b0;
            case (state)
                st_idle: begin
                    if (req_valid) begin
                        state <= st_lookup;
                    end
                end
                st_lookup: begin
                    if (l1_hit) begin
                        state <= st_respond;
                    end else if (victim_hit) begin
                        state <= st_fill;
                    end else begin
                        state     <= st_mem_wait;
                        mem_req_q <= 1'b1;
                    end
                end
                st_mem_wait: begin
                    if (mem_rsp_valid) begin
                        state <= st_fill;
                    end
                end
                st_fill: begin
                    state <= st_respond;
                end
                st_respond: begin
                    state <= st_idle;
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // payload, captured at the step that knows it
    always_ff @(posedge clk) begin
        if (state == st_idle && req_valid) begin
            addr_q <= req.addr;
        end
        if (state == st_lookup) begin
            if (l1_hit) begin
                line_q <= l1_line;
                src_q  <= src_l1;
            end else if (victim_hit) begin
                line_q <= victim_line;
                src_q  <= src_victim;
            end else begin
                src_q <= src_mem;
            end
        end
        if (state == st_mem_wait && mem_rsp_valid) begin
            line_q <= mem_rsp.line;
        end
        // old L1 content, still readable before the fill edge
        if (state == st_fill) begin
            victim_wr_q.line_addr <= {l1_tag, req_index};
            victim_wr_q.line      <= l1_line;
        end
    end

    assign req_ready = (state == st_idle);
    assign rsp_valid = (state == st_respond);
    assign rsp.word  = line_q[req_word*WORD_BITS +: WORD_BITS];
    assign rsp.src   = src_q;

    assign mem_req_valid     = mem_req_q;
    assign mem_req.line_addr = {req_tag, req_index};

    assign l1_fill_en    = (state == st_fill);
    assign l1_fill.index = req_index;
    assign l1_fill.tag   = req_tag;
    assign l1_fill.line  = line_q;

    // held one cycle, victim buffer writes after respond
    assign victim_we = (state == st_fill) && l1_valid;
    assign victim_wr = victim_wr_q;

    mem_rsp_only_when_waiting: assert property (
        @(posedge clk) disable iff (!rstn)
        mem_rsp_valid |-> state == st_mem_wait
    );

    no_req_while_busy: assert property (
        @(posedge clk) disable iff (!rstn)
        !req_ready |-> !req_valid
    );

endmodule

/* logic/icache_top.sv */
// instruction cache top; connects L1 array, victim buffer and miss FSM to fetch and memory ports
`timescale 1ns/100ps

module icache_top (
    input  logic                          clk,
    input  logic                          rstn,
    input  logic                          req_valid,
    input  fetch_types_pkg::fetch_req_t   req,
    output logic                          req_ready,
    output logic                          rsp_valid,
    output fetch_types_pkg::fetch_rsp_t   rsp,
    output logic                          mem_req_valid,
    output fetch_types_pkg::mem_req_t     mem_req,
    input  logic                          mem_rsp_valid,
    input  fetch_types_pkg::mem_rsp_t     mem_rsp
);
    import cache_geom_pkg::*;
    import fetch_types_pkg::*;

    index_t      lookup_index;
    line_addr_t  lookup_line_addr;
    logic        l1_valid;
    tag_t        l1_tag;
    line_t       l1_line;
    logic        l1_fill_en;
    l1_fill_t    l1_fill;
    logic        victim_hit;
    line_t       victim_line;
    logic        victim_we;
    victim_wr_t  victim_wr;

    l1_icache_array u_l1 (
        .clk          (clk),
        .rstn         (rstn),
        .lookup_index (lookup_index),
        .fill_en      (l1_fill_en),
        .fill         (l1_fill),
        .line_valid   (l1_valid),
        .line_tag     (l1_tag),
        .line_data    (l1_line)
    );

    victim_icache u_victim (
        .clk        (clk),
        .rstn       (rstn),
        .r_tag      (lookup_line_addr),
        .we         (victim_we),
        .wr         (victim_wr),
        .victim_hit (victim_hit),
        .data_out   (victim_line)
    );

    icache_miss_ctrl u_ctrl (
        .clk              (clk),
        .rstn             (rstn),
        .req_valid        (req_valid),
        .req              (req),
        .req_ready        (req_ready),
        .rsp_valid        (rsp_valid),
        .rsp              (rsp),
        .mem_req_valid    (mem_req_valid),
        .mem_req          (mem_req),
        .mem_rsp_valid    (mem_rsp_valid),
        .mem_rsp          (mem_rsp),
        .lookup_index     (lookup_index),
        .l1_valid         (l1_valid),
        .l1_tag           (l1_tag),
        .l1_line          (l1_line),
        .l1_fill_en       (l1_fill_en),
        .l1_fill          (l1_fill),
        .lookup_line_addr (lookup_line_addr),
        .victim_hit       (victim_hit),
        .victim_line      (victim_line),
        .victim_we        (victim_we),
        .victim_wr        (victim_wr)
    );

endmodule

/* logic/l1_icache_array.sv */
// direct-mapped L1 instruction storage; combinational set read, line written on a fill pulse
`timescale 1ns/100ps

module l1_icache_array (
    input  logic                       clk,
    input  logic                       rstn,
    input  cache_geom_pkg::index_t     lookup_index,
    input  logic                       fill_en,
    input  fetch_types_pkg::l1_fill_t  fill,
    output logic                       line_valid,
    output cache_geom_pkg::tag_t       line_tag,
    output cache_geom_pkg::line_t      line_data
);
    import cache_geom_pkg::*;

    tag_t              tag_mem  [L1_SETS];
    line_t             data_mem [L1_SETS];
    logic [L1_SETS-1:0] valid_q;

    // lookup is a plain array read
    assign line_valid = valid_q[lookup_index];
    assign line_tag   = tag_mem[lookup_index];
    assign line_data  = data_mem[lookup_index];

    // valid bits are the only control state here
    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid_q <= '0;
        end else if (fill_en) begin
            valid_q[fill.index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_en) begin
            tag_mem[fill.index]  <= fill.tag;
            data_mem[fill.index] <= fill.line;
        end
    end

    // one refill per miss, never back to back
    fill_single_cycle: assert property (
        @(posedge clk) disable iff (!rstn)
        fill_en |=> !fill_en
    );

endmodule

/* logic/victim_icache.sv */
// fully associative victim buffer that stores evicted L1 lines and writes on a rising we edge
`timescale 1ns/100ps

module victim_icache (
    input  logic                          clk,
    input  logic                          rstn,
    input  cache_geom_pkg::line_addr_t    r_tag,
    input  logic                          we,
    input  fetch_types_pkg::victim_wr_t   wr,
    output logic                          victim_hit,
    output cache_geom_pkg::line_t         data_out
);
    import cache_geom_pkg::*;

    line_addr_t                  tag_mem  [VICTIM_ENTRIES];
    line_t                       data_mem [VICTIM_ENTRIES];
    logic [VICTIM_ENTRIES-1:0]   valid_q;
    logic [VICTIM_ENTRIES-1:0]   hit;
    logic [VICTIM_PTR_BITS-1:0]  hit_index;
    logic [VICTIM_PTR_BITS-1:0]  counter;
    logic                        we_now;
    logic                        we_pre;
    logic                        counter_we;

    // compare against every entry at once
    always_comb begin
        for (int i = 0; i < VICTIM_ENTRIES; i++) begin
            hit[i] = valid_q[i] && (tag_mem[i] == r_tag);
        end
    end

    // lowest numbered match wins
    always_comb begin
        hit_index = '0;
        for (int i = VICTIM_ENTRIES - 1; i >= 0; i--) begin
            if (hit[i]) begin
                hit_index = VICTIM_PTR_BITS'(i);
            end
        end
    end

    assign victim_hit = |hit;
    assign data_out   = victim_hit ? data_mem[hit_index] : '0;

    // two stage history of we so the write fires one cycle after the rise
    always_ff @(posedge clk) begin
        if (!rstn) begin
            we_now <= 1'b0;
            we_pre <= 1'b0;
        end else begin
            we_now <= we;
            we_pre <= we_now;
        end
    end

    assign counter_we = we_now && !we_pre;

    // the wrapping counter replaces the oldest entry first
    always_ff @(posedge clk) begin
        if (!rstn) begin
            counter <= '0;
            valid_q <= '0;
        end else if (counter_we) begin
            counter          <= counter + 1'b1;
            valid_q[counter] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (counter_we) begin
            tag_mem[counter]  <= wr.line_addr;
            data_mem[counter] <= wr.line;
        end
    end

    // a held we would merge two evictions into one write
    we_single_cycle: assert property (
        @(posedge clk) disable iff (!rstn)
        we |=> !we
    );

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the instruction cache testbench with Verilator and runs it.
# The exit status is the simulator's own: nonzero when the run fails.

set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f icache_top.f \
    --top-module icache_tb \
    -Mdir obj_dir
build_status=$?
if [ "$build_status" -ne 0 ]; then
    echo "verilator build failed with status $build_status"
    exit "$build_status"
fi

./obj_dir/Vicache_tb
sim_status=$?
if [ "$sim_status" -ne 0 ]; then
    echo "simulation failed with status $sim_status"
    exit "$sim_status"
fi
exit 0

/* tests/icache_tb.sv */
// testbench for icache_top that runs random fetches against a line memory and a reference cache model
`timescale 1ns/100ps

module icache_tb;
    import cache_geom_pkg::*;
    import fetch_types_pkg::*;

    localparam int          CLK_PERIOD_NS = 8;
    localparam int          N_REQ         = 400;
    localparam int          TIMEOUT_NS    = N_REQ * 12 * CLK_PERIOD_NS;
    localparam logic [31:0] SEED          = 32'h600278f2;
    localparam tag_t        TAG_BASE      = 20'h3a000;
    // six tags in one set, then the first tag again once it is five evictions old
    localparam int          DIRECTED_TAGS [9] = '{0, 1, 2, 3, 4, 5, 0, 0, 3};

    logic        clk;
    logic        rstn;
    logic        req_valid;
    fetch_req_t  req;
    logic        req_ready;
    logic        rsp_valid;
    fetch_rsp_t  rsp;
    logic        mem_req_valid;
    mem_req_t    mem_req;
    logic        mem_rsp_valid;
    mem_rsp_t    mem_rsp;

    logic [31:0] rand_state = SEED;

    // reference model state
    bit          l1_v [L1_SETS];
    tag_t        l1_t [L1_SETS];
    line_addr_t  evicted [$];
    bit          seen_line [line_addr_t];

    // the one request in flight
    int          cyc;
    bit          pending;
    int          acc_cyc;
    src_t        exp_src;
    word_t       exp_word;
    line_addr_t  exp_line;
    bit          exp_first;
    bit          mem_req_seen;
    int          mem_rsp_cyc;
    int          n_l1;
    int          n_victim;
    int          n_mem;
    int          n_old_evict;
    int          n_done;

    tb_clock_gen #(.PERIOD_NS(CLK_PERIOD_NS)) u_clk (.clk(clk), .rstn(rstn));

    icache_top uut (
        .clk           (clk),
        .rstn          (rstn),
        .req_valid     (req_valid),
        .req           (req),
        .req_ready     (req_ready),
        .rsp_valid     (rsp_valid),
        .rsp           (rsp),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp       (mem_rsp)
    );

    function automatic logic [31:0] lcg_next();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    // word w of a line is line_addr << 4 | w
    function automatic word_t pattern_word(input line_addr_t la, input int w);
        return (32'(la) << 4) | 32'(w);
    endfunction

    function automatic fetch_addr_t make_addr(input tag_t t, input index_t i, input word_off_t o);
        return {t, i, o, 2'b00};
    endfunction

    task automatic fail_run();
        $display("RESULT: FAIL");
        $fatal(1, "run stopped on the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
            fail_run();
        end
    endtask

    task automatic check_true(input bit cond, input string what);
        assert (cond) else begin
            $display("ERROR %s", what);
            fail_run();
        end
    endtask

    // predicts source and word, then updates the model as the cache would
    task automatic predict(input fetch_addr_t a);
        tag_t       t;
        index_t     i;
        line_addr_t la;
        bit         in_fifo;
        bit         in_old;
        t = a[31:12];
        i = a[11:6];
        la = {t, i};
        in_fifo = 1'b0;
        in_old = 1'b0;
        for (int k = 0; k < evicted.size(); k++) begin
            if (evicted[k] == la && k < VICTIM_ENTRIES) in_fifo = 1'b1;
            if (evicted[k] == la && k >= VICTIM_ENTRIES) in_old = 1'b1;
        end
        exp_first = !seen_line.exists(la);
        seen_line[la] = 1'b1;
        exp_line = la;
        exp_word = pattern_word(la, int'(a[5:2]));
        if (l1_v[i] && l1_t[i] == t) begin
            exp_src = src_l1;
        end else begin
            exp_src = in_fifo ? src_victim : src_mem;
            if (in_old && !in_fifo) n_old_evict++;
            if (l1_v[i]) begin
                evicted.push_front({l1_t[i], i});
                if (evicted.size() > 2 * VICTIM_ENTRIES) void'(evicted.pop_back());
            end
            l1_v[i] = 1'b1;
            l1_t[i] = t;
        end
    endtask

    // outputs settle well before the falling edge
    always @(negedge clk) begin
        cyc = cyc + 1;
        if (rstn) begin
            if (rsp_valid) begin
                check_true(pending, "rsp_valid pulsed with no accepted request");
                if (exp_first) check_value("rsp.src first use", 32'(rsp.src), 32'(src_mem));
                check_value("rsp.src", 32'(rsp.src), 32'(exp_src));
                check_value("rsp.word", rsp.word, exp_word);
                if (exp_src == src_l1) check_value("rsp_valid cycle", cyc, acc_cyc + 2);
                if (exp_src == src_victim) check_value("rsp_valid cycle", cyc, acc_cyc + 3);
                if (exp_src == src_mem) begin
                    check_true(mem_req_seen, "memory response used without a memory request");
                    check_value("rsp_valid cycle", cyc, mem_rsp_cyc + 2);
                end
                if (exp_src == src_l1) n_l1++;
                if (exp_src == src_victim) n_victim++;
                if (exp_src == src_mem) n_mem++;
                n_done++;
                pending = 1'b0;
            end
            if (mem_req_valid) begin
                check_true(pending && exp_src == src_mem && !mem_req_seen,
                           "mem_req_valid raised for a request that needs no memory line");
                check_value("mem_req.line_addr", 32'(mem_req.line_addr), 32'(exp_line));
                check_value("mem_req_valid cycle", cyc, acc_cyc + 2);
                mem_req_seen = 1'b1;
            end
            if (mem_rsp_valid) mem_rsp_cyc = cyc;
            if (req_valid && req_ready) begin
                check_true(!pending, "second request accepted while one is in flight");
                predict(req.addr);
                pending = 1'b1;
                acc_cyc = cyc;
                mem_req_seen = 1'b0;
            end
        end
    end

    // line memory answering after 1 to 4 cycles
    initial begin : memory_model
        line_addr_t la;
        int         delay;
        mem_rsp_valid = 1'b0;
        mem_rsp = '0;
        forever begin
            @(negedge clk);
            if (rstn && mem_req_valid) begin
                la = mem_req.line_addr;
                delay = 1 + int'((lcg_next() >> 24) % 32'd4);
                repeat (delay) @(posedge clk);
                #1;
                for (int w = 0; w < 16; w++) begin
                    mem_rsp.line[w*WORD_BITS +: WORD_BITS] = pattern_word(la, w);
                end
                mem_rsp_valid = 1'b1;
                @(posedge clk);
                #1;
                mem_rsp_valid = 1'b0;
            end
        end
    end

    task automatic issue_request(input fetch_addr_t a);
        while (!req_ready) begin
            @(posedge clk);
            #1;
        end
        req_valid = 1'b1;
        req.addr = a;
        @(posedge clk);
        #1;
        req_valid = 1'b0;
        while (!rsp_valid) begin
            @(posedge clk);
            #1;
        end
    endtask

    initial begin : stimulus
        logic [31:0] r;
        index_t      idx;
        int          gap;
        req_valid = 1'b0;
        req = '0;
        while (rstn !== 1'b1) @(posedge clk);
        @(posedge clk);
        #1;
        check_value("req_ready", 32'(req_ready), 32'd1);
        check_value("rsp_valid", 32'(rsp_valid), 32'd0);
        check_value("mem_req_valid", 32'(mem_req_valid), 32'd0);
        for (int n = 0; n < 9; n++) begin
            issue_request(make_addr(TAG_BASE + tag_t'(DIRECTED_TAGS[n]), 6'd5, word_off_t'(n)));
        end
        // 3 sets and 8 tags keep lines moving between L1 and victim buffer
        for (int n = 9; n < N_REQ; n++) begin
            r = lcg_next();
            case (int'((r >> 12) % 32'd3))
                0: idx = 6'd5;
                1: idx = 6'd17;
                default: idx = 6'd42;
            endcase
            issue_request(make_addr(TAG_BASE + tag_t'(r[27:25]), idx, r[31:28]));
            gap = int'(lcg_next() >> 31);
            repeat (gap) @(posedge clk);
            #1;
        end
        @(posedge clk);
        #1;
        if (n_done == N_REQ && n_l1 > 0 && n_victim > 0 && n_mem > 0 && n_old_evict > 0) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            $display("ERROR not every cache path was exercised, %0d of %0d responses",
                     n_done, N_REQ);
            fail_run();
        end
    end

    initial begin : watchdog
        #(TIMEOUT_NS);
        $display("ERROR timeout, the requests did not complete in %0d ns", TIMEOUT_NS);
        fail_run();
    end

endmodule

/* tests/tb_clock_gen.sv */
// testbench clock and reset source; 8 ns clock, synchronous reset held low for 3 rising edges
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int PERIOD_NS = 8
) (
    output logic clk,
    output logic rstn
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // release shortly after the third edge, like any other driven input
    initial begin
        rstn = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        rstn = 1'b1;
    end

endmodule
